// ==== Bender.yml ====
package:
  name: exu_cluster

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/exu_pkg.sv
      - logic/exu_alu.sv
      - logic/exu_lane.sv
      - logic/exu_dispatch.sv
      - logic/exu_retire.sv
      - logic/exu_cluster.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/exu_cluster_tb.sv

// ==== filelist.f ====
+incdir+logic
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_lane.sv
logic/exu_dispatch.sv
logic/exu_retire.sv
logic/exu_cluster.sv
tests/exu_cluster_tb.sv

// ==== logic/exu_alu.sv ====
`timescale 1ns/100ps

module exu_alu (
    input  exu_pkg::word_t   a,
    input  exu_pkg::word_t   b,
    input  exu_pkg::alu_op_t op,
    output exu_pkg::word_t   result
);

    import exu_pkg::*;

    logic [4:0] shamt;

    // RV32I shifts only look at the low five bits.
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add: begin
                result = a + b;
            end
            op_sub: begin
                result = a - b;
            end
            op_sll: begin
                result = a << shamt;
            end
            op_slt: begin
                result = word_t'($signed(a) < $signed(b));  // 0 or 1.
            end
            op_sltu: begin
                result = word_t'(a < b);
            end
            op_xor: begin
                result = a ^ b;
            end
            op_srl: begin
                result = a >> shamt;
            end
            op_sra: begin
                // Sign bit fills from the left.
                result = word_t'($signed(a) >>> shamt);
            end
            op_or: begin
                result = a | b;
            end
            op_and: begin
                result = a & b;
            end
            op_pass_b: begin
                result = b;  // Upper immediate goes straight through.
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== logic/exu_cluster.sv ====
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_cluster (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  exu_pkg::word_t     pc,
    input  exu_pkg::word_t     imm,
    input  exu_pkg::word_t     rs1_value,
    input  exu_pkg::word_t     rs2_value,
    input  exu_pkg::word_t     rd_value,
    input  exu_pkg::alu_op_t   alu_op,
    input  exu_pkg::a_sel_t    a_sel,
    input  exu_pkg::b_sel_t    b_sel,
    input  logic               invert,
    input  exu_pkg::reg_addr_t rd,
    input  logic               rd_wen,
    output logic               out_valid,
    input  logic               out_ready,
    output exu_pkg::word_t     out_result,
    output exu_pkg::reg_addr_t out_rd,
    output logic               out_rd_wen,
    output exu_pkg::word_t     out_pc,
    output exu_pkg::word_t     retired_count
);

    import exu_pkg::*;

    logic [`EXU_LANES-1:0] issue_valid;   // Dispatcher to lanes.
    logic [`EXU_LANES-1:0] issue_ready;
    logic [`EXU_LANES-1:0] done_valid;    // Lanes to retire unit.
    logic [`EXU_LANES-1:0] done_ready;
    word_t                 done_result [`EXU_LANES];
    reg_addr_t             done_rd [`EXU_LANES];
    logic [`EXU_LANES-1:0] done_rd_wen;
    word_t                 done_pc [`EXU_LANES];

    exu_dispatch u_exu_dispatch (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_valid (issue_valid),
        .lane_ready (issue_ready)
    );

    // Instruction fields fan out to every lane.
    for (genvar i = 0; i < `EXU_LANES; i++) begin : u_lane
        exu_lane u_exu_lane (
            .clock      (clock),
            .reset      (reset),
            .valid_in   (issue_valid[i]),
            .ready_in   (issue_ready[i]),
            .valid_out  (done_valid[i]),
            .ready_out  (done_ready[i]),
            .pc         (pc),
            .imm        (imm),
            .rs1_value  (rs1_value),
            .rs2_value  (rs2_value),
            .rd_value   (rd_value),
            .alu_op     (alu_op),
            .a_sel      (a_sel),
            .b_sel      (b_sel),
            .invert     (invert),
            .rd         (rd),
            .rd_wen     (rd_wen),
            .result     (done_result[i]),
            .rd_out     (done_rd[i]),
            .rd_wen_out (done_rd_wen[i]),
            .pc_out     (done_pc[i])
        );
    end

    exu_retire u_exu_retire (
        .clock         (clock),
        .reset         (reset),
        .lane_valid    (done_valid),
        .lane_ready    (done_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .lane_result   (done_result),
        .lane_rd       (done_rd),
        .lane_rd_wen   (done_rd_wen),
        .lane_pc       (done_pc),
        .out_result    (out_result),
        .out_rd        (out_rd),
        .out_rd_wen    (out_rd_wen),
        .out_pc        (out_pc),
        .retired_count (retired_count)
    );

endmodule

// ==== logic/exu_dispatch.sv ====
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_dispatch (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [`EXU_LANES-1:0] lane_valid,
    input  logic [`EXU_LANES-1:0] lane_ready
);

    import exu_pkg::*;

    lane_idx_t issue_ptr;
    logic      accept;

    // Only the lane under the pointer sees the request.
    always_comb begin
        lane_valid            = '0;
        lane_valid[issue_ptr] = in_valid;
    end

    assign in_ready = lane_ready[issue_ptr];
    assign accept   = in_valid && in_ready;

    // Strict rotation keeps program order across the lanes.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (issue_ptr == lane_idx_t'(`EXU_LANES - 1)) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== logic/exu_lane.sv ====
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_lane (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid_in,
    output logic                ready_in,
    output logic                valid_out,
    input  logic                ready_out,
    input  exu_pkg::word_t      pc,
    input  exu_pkg::word_t      imm,
    input  exu_pkg::word_t      rs1_value,
    input  exu_pkg::word_t      rs2_value,
    input  exu_pkg::word_t      rd_value,
    input  exu_pkg::alu_op_t    alu_op,
    input  exu_pkg::a_sel_t     a_sel,
    input  exu_pkg::b_sel_t     b_sel,
    input  logic                invert,
    input  exu_pkg::reg_addr_t  rd,
    input  logic                rd_wen,
    output exu_pkg::word_t      result,
    output exu_pkg::reg_addr_t  rd_out,
    output logic                rd_wen_out,
    output exu_pkg::word_t      pc_out
);

    import exu_pkg::*;

    logic      valid_q;
    word_t     pc_q;
    word_t     imm_q;
    word_t     rs1_q;
    word_t     rs2_q;
    word_t     rdv_q;
    alu_op_t   alu_op_q;
    a_sel_t    a_sel_q;
    b_sel_t    b_sel_q;
    logic      invert_q;
    reg_addr_t rd_q;
    logic      rd_wen_q;
    word_t     operand_a;
    word_t     operand_b;
    word_t     alu_result;

    // Free when empty, or when the held result leaves this cycle.
    assign ready_in  = !valid_q || ready_out;
    assign valid_out = valid_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (ready_in) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_in && ready_in) begin
            pc_q     <= pc;
            imm_q    <= imm;
            rs1_q    <= rs1_value;
            rs2_q    <= rs2_value;
            rdv_q    <= rd_value;
            alu_op_q <= alu_op;
            a_sel_q  <= a_sel;
            b_sel_q  <= b_sel;
            invert_q <= invert;
            rd_q     <= rd;
            rd_wen_q <= rd_wen;
        end
    end

    always_comb begin
        case (a_sel_q)
            a_rs1:   operand_a = rs1_q;
            a_pc:    operand_a = pc_q;   // auipc and link addresses.
            default: operand_a = '0;
        endcase
        case (b_sel_q)
            b_imm:      operand_b = imm_q;
            b_rs2:      operand_b = rs2_q;
            b_rd_value: operand_b = rdv_q;
            default:    operand_b = '0;
        endcase
    end

    exu_alu u_exu_alu (
        .a      (operand_a),
        .b      (operand_b),
        .op     (alu_op_q),
        .result (alu_result)
    );

    // Flipping bit 0 turns slt into sge.
    assign result     = alu_result ^ {{(`EXU_XLEN-1){1'b0}}, invert_q};
    assign rd_out     = rd_q;
    assign rd_wen_out = rd_wen_q;
    assign pc_out     = pc_q;

endmodule

// ==== logic/exu_pkg.sv ====
`include "exu_settings.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] word_t;      // pc, immediate, operands, result.
    typedef logic [`EXU_REG_AW-1:0] reg_addr_t; // Destination register.
    typedef logic [$clog2(`EXU_LANES)-1:0] lane_idx_t; // Rotation pointers.

    // ALU operation codes.
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_sll    = 4'd2,
        op_slt    = 4'd3,
        op_sltu   = 4'd4,
        op_xor    = 4'd5,
        op_srl    = 4'd6,
        op_sra    = 4'd7,
        op_or     = 4'd8,
        op_and    = 4'd9,
        op_pass_b = 4'd10  // lui.
    } alu_op_t;

    // Operand A source.
    typedef enum logic [1:0] {
        a_rs1  = 2'd0,
        a_pc   = 2'd1,
        a_zero = 2'd2
    } a_sel_t;

    // Operand B source.
    typedef enum logic [1:0] {
        b_imm      = 2'd0,
        b_rs2      = 2'd1,
        b_rd_value = 2'd2,
        b_zero     = 2'd3
    } b_sel_t;

endpackage

// ==== logic/exu_retire.sv ====
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_retire (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`EXU_LANES-1:0] lane_valid,
    output logic [`EXU_LANES-1:0] lane_ready,
    output logic                  out_valid,
    input  logic                  out_ready,
    input  exu_pkg::word_t        lane_result [`EXU_LANES],
    input  exu_pkg::reg_addr_t    lane_rd [`EXU_LANES],
    input  logic [`EXU_LANES-1:0] lane_rd_wen,
    input  exu_pkg::word_t        lane_pc [`EXU_LANES],
    output exu_pkg::word_t        out_result,
    output exu_pkg::reg_addr_t    out_rd,
    output logic                  out_rd_wen,
    output exu_pkg::word_t        out_pc,
    output exu_pkg::word_t        retired_count
);

    import exu_pkg::*;

    lane_idx_t retire_ptr;
    logic      retire;

    // Oldest instruction sits in the lane under the pointer.
    assign out_valid  = lane_valid[retire_ptr];
    assign out_result = lane_result[retire_ptr];
    assign out_rd     = lane_rd[retire_ptr];
    assign out_rd_wen = lane_rd_wen[retire_ptr];
    assign out_pc     = lane_pc[retire_ptr];

    // Other lanes hold their results until their turn.
    always_comb begin
        lane_ready             = '0;
        lane_ready[retire_ptr] = out_ready;
    end

    assign retire = out_valid && out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            retire_ptr <= '0;
        end else if (retire) begin
            if (retire_ptr == lane_idx_t'(`EXU_LANES - 1)) begin
                retire_ptr <= '0;
            end else begin
                retire_ptr <= retire_ptr + 1'b1;
            end
        end
    end

    // Retired instruction count.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            retired_count <= '0;
        end else if (retire) begin
            retired_count <= retired_count + 1'b1;
        end
    end

endmodule

// ==== logic/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Width of pc, operands and results.
`define EXU_XLEN 32

// Width of a register file address.
`define EXU_REG_AW 5

// Execute lanes in the cluster.
// Two is the usual build, three or four also work.
`define EXU_LANES 2

`endif

// ==== tests/exu_cluster_tb.sv ====
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_cluster_tb;

    import exu_pkg::*;

    localparam int SWEEP_LEN      = 11 * 3 * 4 * 2;  // Ops, A sources, B sources, invert.
    localparam int STALL_LEN      = 4 * `EXU_LANES + 8;
    localparam int RANDOM_LEN     = 400;
    localparam int TIMEOUT_CYCLES = (SWEEP_LEN + STALL_LEN + RANDOM_LEN) * 4 + 100;

    logic      clock = 1'b0;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    word_t     pc;
    word_t     imm;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     rd_value;
    alu_op_t   alu_op;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    logic      invert;
    reg_addr_t rd;
    logic      rd_wen;
    logic      out_valid;
    logic      out_ready;
    word_t     out_result;
    reg_addr_t out_rd;
    logic      out_rd_wen;
    word_t     out_pc;
    word_t     retired_count;

    int seed        = 76;
    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int out_count   = 0;
    int cycle_count = 0;

    word_t     exp_result [$];  // Scoreboard, oldest entry first.
    reg_addr_t exp_rd [$];
    logic      exp_rd_wen [$];
    word_t     exp_pc [$];

    always #10 clock = ~clock;

    exu_cluster u_exu_cluster (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .pc            (pc),
        .imm           (imm),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .rd_value      (rd_value),
        .alu_op        (alu_op),
        .a_sel         (a_sel),
        .b_sel         (b_sel),
        .invert        (invert),
        .rd            (rd),
        .rd_wen        (rd_wen),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_rd        (out_rd),
        .out_rd_wen    (out_rd_wen),
        .out_pc        (out_pc),
        .retired_count (retired_count)
    );

    // Reference for one instruction, built from the RV32I rules.
    function automatic word_t model_result(input alu_op_t op, input a_sel_t as, input b_sel_t bs,
                                           input logic inv, input word_t pc_v, input word_t imm_v,
                                           input word_t rs1_v, input word_t rs2_v,
                                           input word_t rdv_v);
        word_t       a;
        word_t       b;
        word_t       r;
        logic [63:0] ext;
        a = (as == a_rs1) ? rs1_v : ((as == a_pc) ? pc_v : 32'h0);
        case (bs)
            b_imm:      b = imm_v;
            b_rs2:      b = rs2_v;
            b_rd_value: b = rdv_v;
            default:    b = 32'h0;
        endcase
        case (op)
            op_add:    r = a + b;
            op_sub:    r = a + ~b + 32'h1;  // Two's complement subtract.
            op_sll:    r = a << b[4:0];
            op_slt:    r = (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
            op_sltu:   r = {31'h0, a < b};
            op_xor:    r = a ^ b;
            op_srl:    r = a >> b[4:0];
            op_sra: begin
                ext = {{32{a[31]}}, a} >> b[4:0];
                r   = ext[31:0];
            end
            op_or:     r = a | b;
            op_and:    r = a & b;
            op_pass_b: r = b;
            default:   r = 32'h0;
        endcase
        r[0] = r[0] ^ inv;
        return r;
    endfunction

    function automatic logic chance(input int percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (expected == actual) else begin
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic drive_fields(input alu_op_t op, input a_sel_t as, input b_sel_t bs,
                                input logic inv);
        pc        <= word_t'($random(seed)) & 32'hffff_fffc;  // Word aligned.
        imm       <= word_t'($random(seed));
        rs1_value <= word_t'($random(seed));
        rs2_value <= word_t'($random(seed));
        rd_value  <= word_t'($random(seed));
        alu_op    <= op;
        a_sel     <= as;
        b_sel     <= bs;
        invert    <= inv;
        rd        <= reg_addr_t'($random(seed));
        rd_wen    <= chance(50);
    endtask

    task automatic drive_random_fields();
        int   op_i;
        logic inv;
        op_i = $unsigned($random(seed)) % 11;
        inv  = (op_i == op_slt || op_i == op_sltu) ? chance(50) : 1'b0;  // sge forms.
        drive_fields(alu_op_t'(op_i[3:0]), a_sel_t'(2'($unsigned($random(seed)) % 3)),
                     b_sel_t'(2'($unsigned($random(seed)) % 4)), inv);
    endtask

    // Holds the fields until the cluster takes them.
    task automatic send_instr(input alu_op_t op, input a_sel_t as, input b_sel_t bs,
                              input logic inv);
        drive_fields(op, as, bs, inv);
        in_valid <= 1'b1;
        @(posedge clock);
        while (!in_ready) begin
            @(posedge clock);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain_cluster();
        out_ready <= 1'b1;
        @(posedge clock);
        while (in_valid && !in_ready) begin
            @(posedge clock);
        end
        in_valid <= 1'b0;
        @(posedge clock);
        while (exp_result.size() != 0) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d %-14s finished with %0d errors", test_count, name,
                 error_count - errors_before);
    endtask

    // Scoreboard. Samples the handshakes just before each edge takes effect.
    always @(posedge clock) begin
        if (!reset) begin
            if (out_valid && out_ready) begin
                out_count++;
                assert (exp_result.size() != 0) else begin
                    $display("A result came out with no instruction outstanding");
                    error_count++;
                end
                if (exp_result.size() != 0) begin
                    check_value("out_result", exp_result.pop_front(), out_result);
                    check_value("out_rd", 32'(exp_rd.pop_front()), 32'(out_rd));
                    check_value("out_rd_wen", 32'(exp_rd_wen.pop_front()), 32'(out_rd_wen));
                    check_value("out_pc", exp_pc.pop_front(), out_pc);
                end
            end
            if (in_valid && in_ready) begin
                exp_result.push_back(model_result(alu_op, a_sel, b_sel, invert, pc, imm,
                                                  rs1_value, rs2_value, rd_value));
                exp_rd.push_back(rd);
                exp_rd_wen.push_back(rd_wen);
                exp_pc.push_back(pc);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the cluster stopped making progress",
                     cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int errors_before;
        int accepted;
        reset     <= 1'b1;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        drive_fields(op_add, a_rs1, b_imm, 1'b0);
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        errors_before = error_count;
        @(posedge clock);
        check_value("out_valid", 32'h0, 32'(out_valid));
        check_value("in_ready", 32'h1, 32'(in_ready));
        check_value("retired_count", 32'h0, retired_count);
        report_test("reset", errors_before);

        // Every op against every operand source, with and without inversion.
        errors_before = error_count;
        out_ready <= 1'b1;
        for (int op_i = 0; op_i < 11; op_i++) begin
            for (int as_i = 0; as_i < 3; as_i++) begin
                for (int bs_i = 0; bs_i < 4; bs_i++) begin
                    for (int inv_i = 0; inv_i < 2; inv_i++) begin
                        send_instr(alu_op_t'(op_i[3:0]), a_sel_t'(as_i[1:0]),
                                   b_sel_t'(bs_i[1:0]), inv_i[0]);
                    end
                end
            end
        end
        drain_cluster();
        report_test("alu sweep", errors_before);

        // Output blocked, so only one instruction per lane fits.
        errors_before = error_count;
        accepted      = 0;
        out_ready <= 1'b0;
        drive_random_fields();
        in_valid <= 1'b1;
        repeat (STALL_LEN) begin
            @(posedge clock);
            if (in_valid && in_ready) begin
                accepted++;
                drive_random_fields();
            end
        end
        assert (accepted == `EXU_LANES) else begin
            $display("With the output blocked the cluster took %0d instructions for %0d lanes",
                     accepted, `EXU_LANES);
            error_count++;
        end
        check_value("in_ready", 32'h0, 32'(in_ready));
        check_value("out_valid", 32'h1, 32'(out_valid));
        drain_cluster();
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        repeat (RANDOM_LEN) begin
            @(posedge clock);
            if (!in_valid || in_ready) begin
                if (chance(70)) begin
                    drive_random_fields();
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= chance(60);
        end
        drain_cluster();
        check_value("retired_count", 32'(out_count), retired_count);
        report_test("random traffic", errors_before);

        $display("Tests: %0d  checks: %0d  errors: %0d  retired: %0d", test_count, check_count,
                 error_count, out_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
